/* common/attn_defs.svh */
/*
  lane count, tile edge, result FIFO depth and datapath widths
*/
`ifndef ATTN_DEFS_SVH
`define ATTN_DEFS_SVH

// lanes per beat, one element each
`define ATTN_N 4

// tile edge, a tile is M*M/N beats
`define ATTN_M 4

// result entries
`define ATTN_FIFO_DEPTH 4

`define ATTN_DATA_W 8
`define ATTN_ACC_W 24
`define ATTN_CNT_W 8

`endif

/* common/attn_pkg.sv */
/*
  vector typedefs, step and layer enums, control struct
*/
package attn_pkg;

  `include "attn_defs.svh"

  // one signed operand element
  typedef logic signed [`ATTN_DATA_W-1:0] data_t;

  // one beat of lanes
  typedef logic [`ATTN_N-1:0][`ATTN_DATA_W-1:0] data_vec_t;

  // accumulator, result and bias word
  typedef logic signed [`ATTN_ACC_W-1:0] acc_t;

  typedef logic [`ATTN_CNT_W-1:0] counter_t;

  // outstanding result credit, counts up to the depth
  typedef logic [$clog2(`ATTN_FIFO_DEPTH+1)-1:0] ongoing_t;

  typedef enum logic {
    Attention,
    Feedforward
  } layer_e;

  typedef enum logic [2:0] {
    Idle,
    Q,
    K,
    V,
    QK,
    AV,
    OW,
    FF
  } step_e;

  typedef struct packed {
    logic     start;
    layer_e   layer;
    counter_t tile_s; // sequence tiles
    counter_t tile_e; // embedding tiles
    counter_t tile_p; // projection tiles
    counter_t tile_f; // feed-forward tiles
  } ctrl_t;

endpackage

/* common/tile_ctrl_if.sv */
/*
  per-beat control from the tile controller to the MAC engine
*/
`timescale 1ns/1ns

interface tile_ctrl_if;

  logic calc_en;          // beat accepted
  logic first_inner_tile; // inner tile index is 0
  logic last_inner_tile;
  logic last_beat;        // final beat of a tile

  modport ctrl (
    output calc_en,
    output first_inner_tile,
    output last_inner_tile,
    output last_beat
  );

  modport engine (
    input calc_en,
    input first_inner_tile,
    input last_inner_tile,
    input last_beat
  );

endinterface

/* verilog/tile_controller.sv */
/*
  step FSM with beat, inner, outer and softmax row counters,
  operand stream gating and result credit count
*/
`timescale 1ns/1ns

`include "attn_defs.svh"

module tile_controller (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  attn_pkg::ctrl_t  ctrl_i,
  input  logic             inp_valid_i,
  input  logic             weight_valid_i,
  input  logic             bias_valid_i,
  output logic             inp_ready_o,
  output logic             weight_ready_o,
  output logic             bias_ready_o,
  input  logic             pop_i,
  tile_ctrl_if.ctrl        ctrl_o,
  output attn_pkg::step_e  step_o,
  output logic             busy_o
);

  import attn_pkg::*;

  localparam int BEATS = `ATTN_M * `ATTN_M / `ATTN_N;

  step_e    step_d, step_q;
  counter_t count_d, count_q;
  counter_t inner_d, inner_q;
  counter_t tile_d, tile_q;
  counter_t soft_d, soft_q;
  ongoing_t ongoing_d, ongoing_q;
  logic     busy_d, busy_q;

  counter_t inner_lim, outer_lim;
  logic     stall, accept;
  logic     first_inner, last_inner, last_beat;

  assign step_o = step_q;
  assign busy_o = busy_q;

  // tile loop bounds of the current step
  always_comb begin
    inner_lim = '0;
    outer_lim = '0;
    case (step_q)
      Q, K, V: begin
        inner_lim = ctrl_i.tile_e;
        outer_lim = counter_t'(ctrl_i.tile_s * ctrl_i.tile_p);
      end
      QK: begin
        inner_lim = ctrl_i.tile_p;
        outer_lim = ctrl_i.tile_s;
      end
      AV: begin
        inner_lim = ctrl_i.tile_s;
        outer_lim = ctrl_i.tile_p;
      end
      OW: begin
        inner_lim = ctrl_i.tile_p;
        outer_lim = counter_t'(ctrl_i.tile_s * ctrl_i.tile_e);
      end
      FF: begin
        inner_lim = ctrl_i.tile_e;
        outer_lim = counter_t'(ctrl_i.tile_s * ctrl_i.tile_f);
      end
      default: ;
    endcase
  end

  assign first_inner = (inner_q == '0);
  assign last_inner  = (inner_q == counter_t'(inner_lim - 1'b1));
  assign last_beat   = (count_q == counter_t'(BEATS - 1));

  // no beats while idle or while the result FIFO may be full
  assign stall = (step_q == Idle) || (ongoing_q >= ongoing_t'(`ATTN_FIFO_DEPTH));

  // each ready follows the valids of its partners
  assign inp_ready_o    = !stall && weight_valid_i && bias_valid_i;
  assign weight_ready_o = !stall && inp_valid_i && bias_valid_i;
  assign bias_ready_o   = !stall && inp_valid_i && weight_valid_i;
  assign accept         = !stall && inp_valid_i && weight_valid_i && bias_valid_i;

  assign ctrl_o.calc_en          = accept;
  assign ctrl_o.first_inner_tile = first_inner;
  assign ctrl_o.last_inner_tile  = last_inner;
  assign ctrl_o.last_beat        = last_beat;

  always_comb begin
    step_d    = step_q;
    count_d   = count_q;
    inner_d   = inner_q;
    tile_d    = tile_q;
    soft_d    = soft_q;
    ongoing_d = ongoing_q;
    busy_d    = busy_q;

    if (ctrl_i.start || accept) begin
      busy_d = 1'b1;
    end

    if (accept) begin
      count_d = count_q + 1'b1;
      if (last_beat) begin
        count_d = '0;
        busy_d  = 1'b0; // tile done
        inner_d = inner_q + 1'b1;
        if (last_inner) begin
          inner_d = '0;
          tile_d  = tile_q + 1'b1;
          if (tile_q == counter_t'(outer_lim - 1'b1)) begin // end of step
            tile_d = '0;
            case (step_q)
              Q:  step_d = K;
              K:  step_d = V;
              V:  step_d = QK;
              QK: step_d = AV;
              AV: begin
                soft_d = soft_q + 1'b1;
                step_d = QK;
                if (soft_q == counter_t'(ctrl_i.tile_s - 1'b1)) begin
                  soft_d = '0;
                  step_d = OW;
                end
              end
              default: step_d = Idle; // OW, FF
            endcase
          end
        end
      end
    end

    if (step_q == Idle) begin
      busy_d = ctrl_i.start;
      if (ctrl_i.start) begin
        step_d = (ctrl_i.layer == Attention) ? Q : FF;
      end
    end

    // credit in beats of last inner tiles, a pop frees a whole tile
    if (accept && last_inner) begin
      ongoing_d = ongoing_d + 1'b1;
    end
    if (pop_i) begin
      ongoing_d = ongoing_d - ongoing_t'(BEATS);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      step_q    <= Idle;
      count_q   <= '0;
      inner_q   <= '0;
      tile_q    <= '0;
      soft_q    <= '0;
      ongoing_q <= '0;
      busy_q    <= 1'b0;
    end else begin
      step_q    <= step_d;
      count_q   <= count_d;
      inner_q   <= inner_d;
      tile_q    <= tile_d;
      soft_q    <= soft_d;
      ongoing_q <= ongoing_d;
      busy_q    <= busy_d;
    end
  end

  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ongoing_q <= ongoing_t'(`ATTN_FIFO_DEPTH))
    else $error("result credit above FIFO depth");

  a_idle_needs_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (step_q == Idle && !ctrl_i.start) |=> (step_q == Idle))
    else $error("step left Idle without start");

endmodule

/* verilog/mac_engine.sv */
/*
  lane dot product with accumulation over inner tiles,
  bias add and result push at the end of an outer tile
*/
`timescale 1ns/1ns

`include "attn_defs.svh"

module mac_engine (
  input  logic              clk_i,
  input  logic              rst_ni,
  tile_ctrl_if.engine       ctrl_i,
  input  attn_pkg::data_vec_t inp_i,
  input  attn_pkg::data_vec_t weight_i,
  input  attn_pkg::acc_t    bias_i,
  output logic              push_o,
  output attn_pkg::acc_t    result_o
);

  import attn_pkg::*;

  localparam int BEATS = `ATTN_M * `ATTN_M / `ATTN_N;

  acc_t dot;
  acc_t acc_d, acc_q;
  acc_t result_q;
  logic first_beat_q; // next beat opens a tile
  logic push_q;
  logic clear;

  // signed lane products summed in accumulator width
  always_comb begin
    dot = '0;
    for (int l = 0; l < `ATTN_N; l++) begin
      dot = dot + acc_t'(data_t'(inp_i[l])) * acc_t'(data_t'(weight_i[l]));
    end
  end

  assign clear = ctrl_i.first_inner_tile && first_beat_q;
  assign acc_d = (clear ? acc_t'(0) : acc_q) + dot;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_beat_q <= 1'b1;
      push_q       <= 1'b0;
    end else begin
      push_q <= ctrl_i.calc_en && ctrl_i.last_inner_tile && ctrl_i.last_beat;
      if (ctrl_i.calc_en) begin
        first_beat_q <= ctrl_i.last_beat;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ctrl_i.calc_en) begin
      acc_q <= acc_d;
      if (ctrl_i.last_inner_tile && ctrl_i.last_beat) begin
        result_q <= acc_d + bias_i; // bias of the final beat
      end
    end
  end

  assign push_o   = push_q;
  assign result_o = result_q;

  a_push_spacing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (BEATS > 1 && push_q) |=> !push_q)
    else $error("result pushed in two consecutive cycles");

endmodule

/* verilog/result_fifo.sv */
/*
  circular result buffer with read/write pointers and fill count
*/
`timescale 1ns/1ns

`include "attn_defs.svh"

module result_fifo (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           push_i,
  input  attn_pkg::acc_t data_i,
  output attn_pkg::acc_t data_o,
  output logic           valid_o,
  input  logic           ready_i,
  output logic           pop_o
);

  import attn_pkg::*;

  localparam int DEPTH = `ATTN_FIFO_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  acc_t             mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] fill_q;
  logic             full;

  assign full    = (fill_q == CNT_W'(DEPTH));
  assign valid_o = (fill_q != '0);
  assign pop_o   = valid_o && ready_i;
  assign data_o  = mem[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_o) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q <= fill_q + CNT_W'(push_i) - CNT_W'(pop_o);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_i && full))
    else $error("push into full result FIFO");

endmodule

/* verilog/attn_core_top.sv */
/*
  top level, tile controller, MAC engine and result FIFO
*/
`timescale 1ns/1ns

module attn_core_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  attn_pkg::layer_e    layer_i,
  input  attn_pkg::counter_t  tile_s_i,
  input  attn_pkg::counter_t  tile_e_i,
  input  attn_pkg::counter_t  tile_p_i,
  input  attn_pkg::counter_t  tile_f_i,
  input  attn_pkg::data_vec_t inp_i,
  input  logic                inp_valid_i,
  output logic                inp_ready_o,
  input  attn_pkg::data_vec_t weight_i,
  input  logic                weight_valid_i,
  output logic                weight_ready_o,
  input  attn_pkg::acc_t      bias_i,
  input  logic                bias_valid_i,
  output logic                bias_ready_o,
  output attn_pkg::acc_t      oup_o,
  output logic                oup_valid_o,
  input  logic                oup_ready_i,
  output attn_pkg::step_e     step_o,
  output logic                busy_o
);

  import attn_pkg::*;

  ctrl_t ctrl;
  logic  push;
  acc_t  result;
  logic  pop;

  assign ctrl = '{
    start:  start_i,
    layer:  layer_i,
    tile_s: tile_s_i,
    tile_e: tile_e_i,
    tile_p: tile_p_i,
    tile_f: tile_f_i
  };

  tile_ctrl_if u_tile_ctrl_if ();

  tile_controller u_tile_controller (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ctrl_i         (ctrl),
    .inp_valid_i    (inp_valid_i),
    .weight_valid_i (weight_valid_i),
    .bias_valid_i   (bias_valid_i),
    .inp_ready_o    (inp_ready_o),
    .weight_ready_o (weight_ready_o),
    .bias_ready_o   (bias_ready_o),
    .pop_i          (pop),
    .ctrl_o         (u_tile_ctrl_if.ctrl),
    .step_o         (step_o),
    .busy_o         (busy_o)
  );

  mac_engine u_mac_engine (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .ctrl_i   (u_tile_ctrl_if.engine),
    .inp_i    (inp_i),
    .weight_i (weight_i),
    .bias_i   (bias_i),
    .push_o   (push),
    .result_o (result)
  );

  result_fifo u_result_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (push),
    .data_i  (result),
    .data_o  (oup_o),
    .valid_o (oup_valid_o),
    .ready_i (oup_ready_i),
    .pop_o   (pop)
  );

endmodule

/* sim/tb_attn_core.sv */
/*
  testbench for attn_core_top with reference model of results and step order,
  concurrent checks on values, handshakes, credit and busy
*/
`timescale 1ns/1ns

`include "attn_defs.svh"

module tb_attn_core;

  import attn_pkg::*;

  localparam int BEATS        = `ATTN_M * `ATTN_M / `ATTN_N;
  localparam int BEAT_TIMEOUT = 200;
  localparam int END_TIMEOUT  = 50;

  logic      clk_i, rst_ni, start_i;
  layer_e    layer_i;
  counter_t  tile_s_i, tile_e_i, tile_p_i, tile_f_i;
  data_vec_t inp_i, weight_i;
  acc_t      bias_i, oup_o;
  logic      inp_valid_i, weight_valid_i, bias_valid_i;
  logic      inp_ready_o, weight_ready_o, bias_ready_o;
  logic      oup_valid_o, oup_ready_i, busy_o;
  step_e     step_o;

  int    seed = 42623;
  int    value_errors = 0;
  int    other_errors = 0;
  logic  timed_out = 1'b0;
  string test_name = "reset";
  logic  chk_idle = 1'b1;
  logic  beat_last = 1'b0;       // driven beat closes a tile
  logic  beat_last_inner = 1'b0; // driven beat is in the last inner tile
  logic  acc_now, any_hs, any_ready;

  acc_t  exp_mem [0:255]; // expected results in order
  int    wr = 0;
  int    rd;
  step_e step_exp [0:63];
  int    step_wr = 0;
  int    step_rd;
  step_e step_prev;
  int    tb_credit;

  attn_core_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  assign any_ready = inp_ready_o || weight_ready_o || bias_ready_o;
  assign acc_now   = inp_valid_i && weight_valid_i && bias_valid_i &&
                     inp_ready_o && weight_ready_o && bias_ready_o;
  assign any_hs    = (inp_valid_i && inp_ready_o) || (weight_valid_i && weight_ready_o) ||
                     (bias_valid_i && bias_ready_o);

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd        <= 0;
      tb_credit <= 0;
      step_prev <= Idle;
      step_rd   <= 0;
    end else begin
      if (oup_valid_o && oup_ready_i) begin
        rd <= rd + 1;
      end
      tb_credit <= tb_credit + ((acc_now && beat_last_inner) ? 1 : 0)
                   - ((oup_valid_o && oup_ready_i) ? BEATS : 0);
      step_prev <= step_o;
      if (step_o != step_prev) begin
        step_rd <= step_rd + 1;
      end
    end
  end

  a_result_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (oup_valid_o && oup_ready_i && rd < wr) |-> (oup_o == exp_mem[rd]))
    else begin
      value_errors++;
      $display("** Error [%s] result %0d: expected %0d, got %0d", test_name,
               $sampled(rd), exp_mem[$sampled(rd)], $sampled(oup_o));
    end

  a_no_extra_result: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (oup_valid_o && oup_ready_i) |-> (rd < wr))
    else begin
      other_errors++;
      $display("[%s] a result came out when none was expected", test_name);
    end

  a_step_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (step_o != step_prev) |-> (step_rd < step_wr && step_o == step_exp[step_rd]))
    else begin
      value_errors++;
      $display("** Error [%s] step: expected %0d, got %0d", test_name,
               step_exp[$sampled(step_rd)], $sampled(step_o));
    end

  a_idle_step: assert property (@(posedge clk_i) disable iff (!rst_ni)
    chk_idle |-> (step_o == Idle))
    else begin
      value_errors++;
      $display("** Error [%s] step: expected %0d, got %0d", test_name, Idle,
               $sampled(step_o));
    end

  a_idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (chk_idle || step_o == Idle) |-> !(any_ready || (chk_idle && (oup_valid_o || busy_o))))
    else begin
      other_errors++;
      $display("[%s] a ready, oup_valid_o or busy_o was high while idle", test_name);
    end

  a_beat_together: assert property (@(posedge clk_i) disable iff (!rst_ni)
    any_hs |-> acc_now)
    else begin
      other_errors++;
      $display("[%s] a stream was accepted without all three valids and readies", test_name);
    end

  a_credit_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (tb_credit >= `ATTN_FIFO_DEPTH) |-> !any_ready)
    else begin
      other_errors++;
      $display("[%s] readies stayed high with the result credit at the FIFO depth", test_name);
    end

  a_busy_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (acc_now && beat_last) |=> !busy_o)
    else begin
      other_errors++;
      $display("[%s] busy_o stayed high after the last beat of a tile", test_name);
    end

  a_busy_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (start_i || (acc_now && !beat_last)) |=> busy_o)
    else begin
      other_errors++;
      $display("[%s] busy_o did not rise after start or an accepted beat", test_name);
    end

  function automatic acc_t beat_dot(input data_vec_t a, input data_vec_t b);
    int sum;
    sum = 0;
    for (int l = 0; l < `ATTN_N; l++) begin
      sum += int'($signed(a[l])) * int'($signed(b[l]));
    end
    return acc_t'(sum);
  endfunction

  function automatic logic coin_flip();
    int r;
    r = $random(seed);
    return r[0];
  endfunction

  // drives one operand beat and holds it until all three streams take it
  task automatic send_beat(input logic last_inner, input logic last_b, input logic gaps,
                           output acc_t dot, output acc_t bias);
    logic [31:0] rnd;
    int          waited;
    logic        accepted;
    waited   = 0;
    accepted = 1'b0;
    inp_i    = $random(seed);
    weight_i = $random(seed);
    rnd      = $random(seed);
    bias_i   = rnd[`ATTN_ACC_W-1:0];
    beat_last_inner = last_inner;
    beat_last       = last_b;
    dot  = beat_dot(inp_i, weight_i);
    bias = bias_i;
    while (!accepted && !timed_out) begin
      if (!inp_valid_i) inp_valid_i = !gaps || coin_flip();
      if (!weight_valid_i) weight_valid_i = !gaps || coin_flip();
      if (!bias_valid_i) bias_valid_i = !gaps || coin_flip();
      @(negedge clk_i);
      accepted = inp_valid_i && weight_valid_i && bias_valid_i && inp_ready_o;
      @(posedge clk_i);
      #1;
      waited++;
      if (!accepted && waited > BEAT_TIMEOUT) begin
        other_errors++;
        timed_out = 1'b1;
        $display("[%s] timeout, a beat was not accepted in %0d cycles", test_name, waited);
      end
    end
    inp_valid_i    = 1'b0;
    weight_valid_i = 1'b0;
    bias_valid_i   = 1'b0;
  endtask

  // one layer run with steps and results expected from the tile table
  task automatic run_layer(input string name, input layer_e layer, input int s, input int e,
                           input int p, input int f, input logic gaps);
    step_e seq [$];
    int    outer [$];
    int    inner [$];
    step_e qkv [3] = '{Q, K, V};
    int    n_results;
    int    first_rd;
    int    waited;
    acc_t  acc, dot, bias;
    n_results = 0;
    waited    = 0;
    test_name = name;
    if (layer == Attention) begin
      for (int k = 0; k < 3; k++) begin
        seq.push_back(qkv[k]);
        outer.push_back(s * p);
        inner.push_back(e);
      end
      for (int r = 0; r < s; r++) begin
        seq.push_back(QK);
        outer.push_back(s);
        inner.push_back(p);
        seq.push_back(AV);
        outer.push_back(p);
        inner.push_back(s);
      end
      seq.push_back(OW);
      outer.push_back(s * e);
      inner.push_back(p);
    end else begin
      seq.push_back(FF);
      outer.push_back(s * f);
      inner.push_back(e);
    end
    foreach (seq[i]) begin
      step_exp[step_wr] = seq[i];
      step_wr++;
      n_results += outer[i];
    end
    step_exp[step_wr] = Idle;
    step_wr++;
    first_rd = wr;
    layer_i  = layer;
    tile_s_i = counter_t'(s);
    tile_e_i = counter_t'(e);
    tile_p_i = counter_t'(p);
    tile_f_i = counter_t'(f);
    start_i  = 1'b1;
    @(posedge clk_i);
    #1;
    start_i = 1'b0;
    foreach (seq[i]) begin
      for (int o = 0; o < outer[i]; o++) begin
        acc = '0;
        for (int t = 0; t < inner[i]; t++) begin
          for (int b = 0; b < BEATS; b++) begin
            send_beat(t == inner[i] - 1, b == BEATS - 1, gaps, dot, bias);
            acc = acc + dot;
            if (t == inner[i] - 1 && b == BEATS - 1) begin
              exp_mem[wr] = acc + bias;
              wr++;
            end
          end
        end
      end
    end
    while (!(step_o == Idle && rd == wr) && !timed_out) begin
      @(posedge clk_i);
      #1;
      waited++;
      if (waited > END_TIMEOUT) begin
        timed_out = 1'b1;
        if (rd - first_rd != n_results) begin
          value_errors++;
          $display("** Error [%s] results: expected %0d, got %0d", name, n_results,
                   rd - first_rd);
        end else begin
          other_errors++;
          $display("[%s] timeout, run did not return to idle", name);
        end
      end
    end
    @(posedge clk_i);
    #1;
    if (!timed_out && step_rd != step_wr) begin
      value_errors++;
      $display("** Error [%s] step changes: expected %0d, got %0d", name, step_wr, step_rd);
    end
  endtask

  initial begin
    rst_ni         = 1'b0;
    start_i        = 1'b0;
    layer_i        = Attention;
    tile_s_i       = '0;
    tile_e_i       = '0;
    tile_p_i       = '0;
    tile_f_i       = '0;
    inp_i          = '0;
    weight_i       = '0;
    bias_i         = '0;
    inp_valid_i    = 1'b0;
    weight_valid_i = 1'b0;
    bias_valid_i   = 1'b0;
    oup_ready_i    = 1'b1;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // valids offered while idle must not be taken
    inp_valid_i    = 1'b1;
    weight_valid_i = 1'b1;
    bias_valid_i   = 1'b1;
    repeat (6) @(posedge clk_i);
    #1;
    chk_idle       = 1'b0;
    inp_valid_i    = 1'b0;
    weight_valid_i = 1'b0;
    bias_valid_i   = 1'b0;

    run_layer("ff_basic", Feedforward, 2, 2, 1, 1, 1'b0);
    run_layer("attn_unit", Attention, 1, 1, 1, 1, 1'b0);
    run_layer("attn_rows", Attention, 2, 1, 1, 1, 1'b0);

    oup_ready_i = 1'b0;
    fork
      run_layer("backpressure", Feedforward, 2, 1, 1, 2, 1'b0);
      begin
        repeat (40) @(posedge clk_i);
        #1;
        oup_ready_i = 1'b1;
      end
    join

    run_layer("valid_gaps", Feedforward, 2, 2, 1, 2, 1'b1);

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+common
common/attn_pkg.sv
common/tile_ctrl_if.sv
verilog/tile_controller.sv
verilog/mac_engine.sv
verilog/result_fifo.sv
verilog/attn_core_top.sv
sim/tb_attn_core.sv
